// File: files.f
verilog/issue_pkg.sv
verilog/instr_decoder.sv
verilog/operand_bypass.sv
verilog/issue_control.sv
verilog/dispatch_regs.sv
verilog/issue_stage.sv
tb/tb_clock_gen.sv
tb/tb_issue_stage.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module tb_issue_stage -o sim_issue_stage \
    && ./obj_dir/sim_issue_stage | tee /dev/stderr | grep -qx "STATUS: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset held for 10 rising edges, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/tb_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage;
    import issue_pkg::*;

    // one stimulus row, full = {rob, alu station, cmp station}
    typedef struct packed {
        logic                 valid;
        word_t                instr;
        word_t                pc;
        word_t                imm;
        rob_tag_t             qj;
        rob_tag_t             qk;
        logic [ROB_DEPTH-1:0] ready;
        logic [2:0]           full;
        rob_tag_t             free_tag;
        logic                 exp_read;
        unit_e                exp_unit;
        alu_op_e              exp_op;
    } row_t;

    logic       clk;
    logic       rst;
    iq_entry_t  iq_entry;
    logic       iq_read;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_src_t   reg_src;
    rob_view_t  rob_view;
    logic       rob_full;
    rob_tag_t   free_tag;
    logic       alu_full;
    logic       cmp_full;
    alu_entry_t alu_entry;
    cmp_entry_t cmp_entry;
    logic       rob_write;
    rob_entry_t rob_entry;
    logic       tag_write;
    reg_idx_t   tag_rd;
    rob_tag_t   tag;

    row_t        rows[$];
    string       names[$];
    string       cur_name;
    logic [31:0] lfsr = 32'h1993_1e01;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit;

    tb_clock_gen clock_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    issue_stage dut_i (
        .clk            (clk),
        .rst            (rst),
        .iq_entry_i     (iq_entry),
        .iq_read_o      (iq_read),
        .rs1_o          (rs1),
        .rs2_o          (rs2),
        .reg_src_i      (reg_src),
        .rob_i          (rob_view),
        .rob_full_i     (rob_full),
        .rob_free_tag_i (free_tag),
        .alu_rs_full_i  (alu_full),
        .cmp_rs_full_i  (cmp_full),
        .alu_o          (alu_entry),
        .cmp_o          (cmp_entry),
        .rob_write_o    (rob_write),
        .rob_entry_o    (rob_entry),
        .tag_write_o    (tag_write),
        .tag_rd_o       (tag_rd),
        .tag_o          (tag)
    );

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic word_t next_word();
        word_t w;
        w = '0;
        for (int b = 0; b < XLEN; b++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[XLEN-2:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic word_t r_format(input logic [6:0] f7, input reg_idx_t src2,
            input reg_idx_t src1, input logic [2:0] f3, input reg_idx_t rd);
        return {f7, src2, src1, f3, rd, op_reg};
    endfunction

    function automatic word_t i_format(input word_t imm, input reg_idx_t src1,
            input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
        return {imm[11:0], src1, f3, rd, op};
    endfunction

    function automatic word_t u_format(input word_t imm, input reg_idx_t rd,
            input logic [6:0] op);
        return {imm[31:12], rd, op};
    endfunction

    function automatic word_t b_format(input word_t off, input reg_idx_t src2,
            input reg_idx_t src1, input logic [2:0] f3);
        return {off[12], off[10:5], src2, src1, f3, off[4:1], off[11], op_br};
    endfunction

    // producer slot that is ready hands over its value
    function automatic operand_t resolve_operand(input word_t value, input rob_tag_t q,
            input rob_view_t view);
        operand_t o;
        o.value = value;
        o.tag   = q;
        if (q != 0 && view[q].ready) begin
            o.value = view[q].value;
            o.tag   = 0;
        end
        o.valid = (o.tag == 0);
        return o;
    endfunction

    function automatic operand_t ready_operand(input word_t value);
        operand_t o;
        o.value = value;
        o.valid = 1'b1;
        o.tag   = '0;
        return o;
    endfunction

    task automatic check_val(input string what, input logic [143:0] exp,
            input logic [143:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: %s expected %0h, actual %0h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_strobes(input unit_e unit);
        check_val("alu valid", 144'(unit == unit_alu), 144'(alu_entry.valid));
        check_val("cmp valid", 144'(unit == unit_cmp), 144'(cmp_entry.valid));
        check_val("rob_write", 144'(unit != unit_none), 144'(rob_write));
        check_val("tag_write", 144'(unit == unit_alu), 144'(tag_write));
    endtask

    task automatic add_row(input string name, input logic valid, input word_t instr,
            input word_t imm, input rob_tag_t qj, input rob_tag_t qk,
            input logic [ROB_DEPTH-1:0] ready, input logic [2:0] full,
            input rob_tag_t free, input logic exp_read, input unit_e exp_unit,
            input alu_op_e exp_op);
        row_t r;
        r.valid    = valid;
        r.instr    = instr;
        r.pc       = 32'h1000 + 4 * rows.size();
        r.imm      = imm;
        r.qj       = qj;
        r.qk       = qk;
        r.ready    = ready;
        r.full     = full;
        r.free_tag = free;
        r.exp_read = exp_read;
        r.exp_unit = exp_unit;
        r.exp_op   = exp_op;
        rows.push_back(r);
        names.push_back(name);
    endtask

    // name, valid, instr, imm, qj, qk, ready slots, full, free tag, read, unit, op
    task automatic build_table();
        add_row("add", 1, r_format(0, 2, 1, F3_ADD, 3), 0, 0, 0, 0, 0, 3, 1, unit_alu, alu_add);
        add_row("sub", 1, r_format('h20, 4, 5, F3_ADD, 6), 0, 0, 0, 0, 0, 5, 1, unit_alu, alu_sub);
        // slot 0 ready, tag 0 still takes the register value
        add_row("sll", 1, r_format(0, 7, 8, F3_SLL, 9), 0, 0, 0, 'h01, 0, 1, 1,
                unit_alu, alu_sll);
        add_row("xor", 1, r_format(0, 3, 2, F3_XOR, 4), 0, 0, 0, 0, 0, 7, 1, unit_alu, alu_xor);
        add_row("or", 1, r_format(0, 6, 5, F3_OR, 7), 0, 0, 0, 0, 0, 2, 1, unit_alu, alu_or);
        add_row("and", 1, r_format(0, 9, 8, F3_AND, 10), 0, 0, 0, 0, 0, 4, 1, unit_alu, alu_and);
        add_row("bypass_ready", 1, r_format(0, 2, 1, F3_ADD, 3), 0, 2, 6, 'h44, 0, 6, 1,
                unit_alu, alu_add);
        add_row("bypass_wait", 1, r_format(0, 2, 1, F3_XOR, 3), 0, 3, 5, 'h20, 0, 1, 1,
                unit_alu, alu_xor);
        add_row("addi_neg", 1, i_format('hFFFF_FFFB, 1, F3_ADD, 6, op_imm), 'hFFFF_FFFB,
                0, 0, 0, 0, 3, 1, unit_alu, alu_add);
        // bit 30 set in the immediate must not turn into sub
        add_row("addi_bit30", 1, i_format('h400, 1, F3_ADD, 6, op_imm), 'h400, 4, 0, 'h10, 0, 2, 1,
                unit_alu, alu_add);
        add_row("xori", 1, i_format('h2A5, 3, F3_XOR, 7, op_imm), 'h2A5, 0, 0, 0, 0, 5, 1,
                unit_alu, alu_xor);
        add_row("andi", 1, i_format('hFFFF_F800, 4, F3_AND, 8, op_imm), 'hFFFF_F800, 0, 0, 0, 0,
                6, 1, unit_alu, alu_and);
        add_row("slli", 1, i_format(3, 5, F3_SLL, 9, op_imm), 3, 0, 0, 0, 0, 7, 1, unit_alu, alu_sll);
        add_row("auipc", 1, u_format('h1234_5000, 9, op_auipc), 'h1234_5000, 0, 0, 0, 0, 1, 1,
                unit_alu, alu_add);
        add_row("auipc_neg", 1, u_format('hFFFF_F000, 10, op_auipc), 'hFFFF_F000, 0, 0, 0, 0, 4, 1,
                unit_alu, alu_add);
        add_row("beq", 1, b_format(16, 2, 1, 0), 16, 5, 0, 'h20, 0, 2, 1, unit_cmp, alu_add);
        add_row("bne", 1, b_format('hFFFF_FFF8, 3, 4, 1), 'hFFFF_FFF8, 0, 4, 0, 0, 3, 1,
                unit_cmp, alu_add);
        add_row("blt", 1, b_format('hFFFF_F000, 5, 6, 4), 'hFFFF_F000, 0, 0, 0, 0, 6, 1,
                unit_cmp, alu_add);
        add_row("rob_full", 1, r_format(0, 2, 1, F3_ADD, 3), 0, 0, 0, 0, 'b100, 3, 0,
                unit_none, alu_add);
        add_row("alu_full", 1, r_format(0, 2, 1, F3_ADD, 3), 0, 0, 0, 0, 'b010, 3, 0,
                unit_none, alu_add);
        add_row("no_free_tag", 1, r_format(0, 2, 1, F3_ADD, 3), 0, 0, 0, 0, 0, 0, 0,
                unit_none, alu_add);
        add_row("cmp_full_br", 1, b_format(16, 2, 1, 0), 16, 0, 0, 0, 'b001, 2, 0,
                unit_none, alu_add);
        add_row("alu_full_br", 1, b_format(16, 2, 1, 0), 16, 0, 0, 0, 'b010, 2, 1,
                unit_cmp, alu_add);
        add_row("cmp_full_add", 1, r_format(0, 2, 1, F3_ADD, 3), 0, 0, 0, 0, 'b001, 5, 1,
                unit_alu, alu_add);
        add_row("rd0_add", 1, r_format(0, 2, 1, F3_ADD, 0), 0, 0, 0, 0, 0, 3, 1, unit_none, alu_add);
        add_row("rd0_alu_full", 1, r_format(0, 2, 1, F3_ADD, 0), 0, 0, 0, 0, 'b010, 3, 1,
                unit_none, alu_add);
        add_row("lui", 1, u_format('hABCD_E000, 5, op_lui), 0, 0, 0, 0, 0, 3, 1, unit_none, alu_add);
        add_row("slt", 1, r_format(0, 2, 1, 2, 5), 0, 0, 0, 0, 0, 3, 1, unit_none, alu_add);
        add_row("srai", 1, i_format('h403, 1, 5, 5, op_imm), 0, 0, 0, 0, 0, 3, 1, unit_none, alu_add);
        add_row("jal", 1, u_format(0, 1, 'h6F), 0, 0, 0, 0, 0, 3, 1, unit_none, alu_add);
        add_row("lui_rob_full", 1, u_format('hABCD_E000, 5, op_lui), 0, 0, 0, 0, 'b100, 3, 0,
                unit_none, alu_add);
        add_row("invalid", 0, r_format(0, 2, 1, F3_ADD, 3), 0, 0, 0, 0, 0, 3, 0, unit_none, alu_add);
        add_row("add_after_idle", 1, r_format(0, 2, 1, F3_OR, 11), 0, 0, 0, 0, 0, 7, 1,
                unit_alu, alu_or);
    endtask

    // drive on the falling edge, check read mid-cycle and outputs one edge later
    task automatic run_row(input int idx);
        row_t       r;
        word_t      vj;
        word_t      vk;
        rob_view_t  view;
        operand_t   opnd_j;
        operand_t   opnd_k;
        alu_entry_t exp_alu;
        cmp_entry_t exp_cmp;
        rob_entry_t exp_rob;
        logic [6:0] opcode;
        r        = rows[idx];
        cur_name = names[idx];
        vj       = next_word();
        vk       = next_word();
        for (int k = 0; k < ROB_DEPTH; k++) begin
            view[k].ready = r.ready[k];
            view[k].value = next_word();
        end

        iq_entry.valid = r.valid;
        iq_entry.pc    = r.pc;
        iq_entry.instr = r.instr;
        reg_src.vj     = vj;
        reg_src.vk     = vk;
        reg_src.qj     = r.qj;
        reg_src.qk     = r.qk;
        rob_view       = view;
        rob_full       = r.full[2];
        alu_full       = r.full[1];
        cmp_full       = r.full[0];
        free_tag       = r.free_tag;

        opcode         = r.instr[6:0];
        opnd_j         = resolve_operand(vj, r.qj, view);
        opnd_k         = resolve_operand(vk, r.qk, view);
        // auipc takes the pc as rs1, immediate forms take imm as rs2
        exp_alu.valid   = 1'b1;
        exp_alu.rs1     = (opcode == op_auipc) ? ready_operand(r.pc) : opnd_j;
        exp_alu.rs2     = (opcode == op_reg) ? opnd_k : ready_operand(r.imm);
        exp_alu.op      = r.exp_op;
        exp_alu.rob_idx = r.free_tag;
        exp_cmp.valid   = 1'b1;
        exp_cmp.rs1     = opnd_j;
        exp_cmp.rs2     = opnd_k;
        exp_cmp.pc      = r.pc;
        exp_cmp.b_imm   = r.imm;
        exp_cmp.funct3  = r.instr[14:12];
        exp_cmp.rob_idx = r.free_tag;
        exp_rob.instr_pc = r.pc;
        exp_rob.opcode   = opcode;
        exp_rob.rd       = r.instr[11:7];

        #10;
        check_val("iq_read", 144'(r.exp_read), 144'(iq_read));
        // register file read indices
        check_val("rs1", 144'(r.instr[19:15]), 144'(rs1));
        check_val("rs2", 144'(r.instr[24:20]), 144'(rs2));
        @(negedge clk);
        check_strobes(r.exp_unit);
        if (r.exp_unit == unit_alu) begin
            check_val("alu entry", 144'(exp_alu), 144'(alu_entry));
            check_val("tag_rd", 144'(exp_rob.rd), 144'(tag_rd));
            check_val("tag", 144'(r.free_tag), 144'(tag));
        end
        if (r.exp_unit == unit_cmp) begin
            check_val("cmp entry", 144'(exp_cmp), 144'(cmp_entry));
        end
        if (r.exp_unit != unit_none) begin
            check_val("rob entry", 144'(exp_rob), 144'(rob_entry));
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: test did not finish within %0d cycles", limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        iq_entry = '0;
        reg_src  = '0;
        rob_view = '0;
        rob_full = 1'b0;
        free_tag = '0;
        alu_full = 1'b0;
        cmp_full = 1'b0;
        build_table();
        limit = rows.size() * 3 + 20;

        @(negedge rst);
        cur_name = "reset";
        check_strobes(unit_none);
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/dispatch_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_alu_i,
    input  logic                  issue_cmp_i,
    input  issue_pkg::word_t      pc_i,
    input  issue_pkg::decoded_t   dec_i,
    input  logic [6:0]            opcode_i,
    input  issue_pkg::operand_t   rs1_i,
    input  issue_pkg::operand_t   rs2_i,
    input  issue_pkg::rob_tag_t   free_tag_i,
    output issue_pkg::alu_entry_t alu_o,
    output issue_pkg::cmp_entry_t cmp_o,
    output logic                  rob_write_o,
    output issue_pkg::rob_entry_t rob_entry_o,
    output logic                  tag_write_o,
    output issue_pkg::reg_idx_t   tag_rd_o,
    output issue_pkg::rob_tag_t   tag_o
);
    import issue_pkg::*;

    operand_t   op_a;
    operand_t   op_b;
    alu_entry_t alu_d;
    cmp_entry_t cmp_d;

    // pc and immediate enter as ready operands
    always_comb begin
        op_a = rs1_i;
        op_b = rs2_i;
        if (dec_i.use_pc) begin
            op_a = '{value: pc_i, valid: 1'b1, tag: '0};
        end
        if (dec_i.use_imm) begin
            op_b = '{value: dec_i.imm, valid: 1'b1, tag: '0};
        end
    end

    always_comb begin
        alu_d.valid   = issue_alu_i;
        alu_d.rs1     = op_a;
        alu_d.rs2     = op_b;
        alu_d.op      = dec_i.alu_op;
        alu_d.rob_idx = free_tag_i;

        cmp_d.valid   = issue_cmp_i;
        cmp_d.rs1     = rs1_i;
        cmp_d.rs2     = rs2_i;
        cmp_d.pc      = pc_i;
        cmp_d.b_imm   = dec_i.b_imm;
        cmp_d.funct3  = dec_i.funct3;
        cmp_d.rob_idx = free_tag_i;
    end

    always_ff @(posedge clk) begin
        alu_o                <= alu_d;
        cmp_o                <= cmp_d;
        rob_entry_o.instr_pc <= pc_i;
        rob_entry_o.opcode   <= opcode_i;
        rob_entry_o.rd       <= dec_i.rd;
        tag_rd_o             <= dec_i.rd;
        tag_o                <= free_tag_i;
        // strobes last one cycle
        rob_write_o          <= issue_alu_i || issue_cmp_i;
        tag_write_o          <= issue_alu_i;
        if (rst) begin
            alu_o.valid <= 1'b0;
            cmp_o.valid <= 1'b0;
            rob_write_o <= 1'b0;
            tag_write_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  issue_pkg::word_t    instr_i,
    output issue_pkg::decoded_t dec_o,
    output issue_pkg::reg_idx_t rs1_o,
    output issue_pkg::reg_idx_t rs2_o
);
    import issue_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       sub_sel;
    logic       arith_ok;
    alu_op_e    arith_op;
    word_t      i_imm;
    word_t      u_imm;
    word_t      b_imm;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    // sign-extended immediates
    assign i_imm = {{21{instr_i[31]}}, instr_i[30:20]};
    assign u_imm = {instr_i[31:12], 12'h000};
    assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    // funct7 bit 5 selects sub for register ops only
    assign sub_sel = (opcode == op_reg) && instr_i[30];

    // funct3 to alu op, shared by reg and imm forms
    always_comb begin
        arith_ok = 1'b1;
        arith_op = alu_add;
        case (funct3)
            F3_ADD: arith_op = sub_sel ? alu_sub : alu_add;
            F3_SLL: arith_op = alu_sll;
            F3_XOR: arith_op = alu_xor;
            F3_OR:  arith_op = alu_or;
            F3_AND: arith_op = alu_and;
            // slt, sltu and right shifts
            default: arith_ok = 1'b0;
        endcase
    end

    always_comb begin
        dec_o         = '0;
        dec_o.unit    = unit_none;
        dec_o.alu_op  = arith_op;
        dec_o.funct3  = funct3;
        dec_o.rd      = instr_i[11:7];
        dec_o.imm     = i_imm;
        dec_o.b_imm   = b_imm;
        case (opcode)
            op_reg: begin
                if (arith_ok) begin
                    dec_o.unit = unit_alu;
                end
            end
            op_imm: begin
                dec_o.use_imm = 1'b1;
                if (arith_ok) begin
                    dec_o.unit = unit_alu;
                end
            end
            op_auipc: begin
                // pc + upper immediate
                dec_o.unit    = unit_alu;
                dec_o.alu_op  = alu_add;
                dec_o.use_pc  = 1'b1;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = u_imm;
            end
            op_br: begin
                dec_o.unit = unit_cmp;
            end
            // lui and anything unknown is consumed without issue
            default: dec_o.unit = unit_none;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/issue_control.sv
`timescale 1ns/1ps
`default_nettype none

module issue_control (
    input  logic                entry_valid_i,
    input  issue_pkg::unit_e    unit_i,
    input  issue_pkg::reg_idx_t rd_i,
    input  logic                rob_full_i,
    input  issue_pkg::rob_tag_t rob_free_tag_i,
    input  logic                alu_rs_full_i,
    input  logic                cmp_rs_full_i,
    output logic                iq_read_o,
    output logic                issue_alu_o,
    output logic                issue_cmp_o
);
    import issue_pkg::*;

    logic alu_room;
    logic cmp_room;

    // a free ROB tag plus a slot in the target station
    assign alu_room = (rob_free_tag_i != '0) && !alu_rs_full_i;
    assign cmp_room = (rob_free_tag_i != '0) && !cmp_rs_full_i;

    always_comb begin
        iq_read_o   = 1'b0;
        issue_alu_o = 1'b0;
        issue_cmp_o = 1'b0;
        if (entry_valid_i && !rob_full_i) begin
            case (unit_i)
                unit_none: iq_read_o = 1'b1;
                unit_alu: begin
                    if (rd_i == '0) begin
                        // write to x0, drop it
                        iq_read_o = 1'b1;
                    end else if (alu_room) begin
                        iq_read_o   = 1'b1;
                        issue_alu_o = 1'b1;
                    end
                end
                unit_cmp: begin
                    if (cmp_room) begin
                        iq_read_o   = 1'b1;
                        issue_cmp_o = 1'b1;
                    end
                end
                default: iq_read_o = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/issue_pkg.sv
`default_nettype none

package issue_pkg;

    // data path widths
    localparam int XLEN = 32;
    localparam int ROB_DEPTH = 8;
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH);

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;
    // tag 0 means the value is ready
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // supported RV32I major opcodes
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_br    = 7'b1100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // arithmetic funct3 values
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sub = 3'b010,
        alu_xor = 3'b100,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        unit_none = 2'd0,
        unit_alu  = 2'd1,
        unit_cmp  = 2'd2
    } unit_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } iq_entry_t;

    typedef struct packed {
        word_t    vj;
        word_t    vk;
        rob_tag_t qj;
        rob_tag_t qk;
    } reg_src_t;

    typedef struct packed {
        logic  ready;
        word_t value;
    } rob_slot_t;

    typedef rob_slot_t [ROB_DEPTH-1:0] rob_view_t;

    typedef struct packed {
        word_t    value;
        logic     valid;
        rob_tag_t tag;
    } operand_t;

    typedef struct packed {
        unit_e      unit;
        alu_op_e    alu_op;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic       use_pc;
        logic       use_imm;
        word_t      imm;
        word_t      b_imm;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        operand_t rs1;
        operand_t rs2;
        alu_op_e  op;
        rob_tag_t rob_idx;
    } alu_entry_t;

    typedef struct packed {
        logic       valid;
        operand_t   rs1;
        operand_t   rs2;
        word_t      pc;
        word_t      b_imm;
        logic [2:0] funct3;
        rob_tag_t   rob_idx;
    } cmp_entry_t;

    typedef struct packed {
        word_t      instr_pc;
        logic [6:0] opcode;
        reg_idx_t   rd;
    } rob_entry_t;

endpackage

`default_nettype wire

// File: verilog/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  issue_pkg::iq_entry_t  iq_entry_i,
    output logic                  iq_read_o,
    output issue_pkg::reg_idx_t   rs1_o,
    output issue_pkg::reg_idx_t   rs2_o,
    input  issue_pkg::reg_src_t   reg_src_i,
    input  issue_pkg::rob_view_t  rob_i,
    input  logic                  rob_full_i,
    input  issue_pkg::rob_tag_t   rob_free_tag_i,
    input  logic                  alu_rs_full_i,
    input  logic                  cmp_rs_full_i,
    output issue_pkg::alu_entry_t alu_o,
    output issue_pkg::cmp_entry_t cmp_o,
    output logic                  rob_write_o,
    output issue_pkg::rob_entry_t rob_entry_o,
    output logic                  tag_write_o,
    output issue_pkg::reg_idx_t   tag_rd_o,
    output issue_pkg::rob_tag_t   tag_o
);
    import issue_pkg::*;

    decoded_t dec;
    operand_t opnd_j;
    operand_t opnd_k;
    logic     issue_alu;
    logic     issue_cmp;

    instr_decoder u_decoder (
        .instr_i (iq_entry_i.instr),
        .dec_o   (dec),
        .rs1_o   (rs1_o),
        .rs2_o   (rs2_o)
    );

    // register file answers in the same cycle
    operand_bypass u_bypass_j (
        .value_i (reg_src_i.vj),
        .tag_i   (reg_src_i.qj),
        .rob_i   (rob_i),
        .opnd_o  (opnd_j)
    );

    operand_bypass u_bypass_k (
        .value_i (reg_src_i.vk),
        .tag_i   (reg_src_i.qk),
        .rob_i   (rob_i),
        .opnd_o  (opnd_k)
    );

    issue_control u_control (
        .entry_valid_i  (iq_entry_i.valid),
        .unit_i         (dec.unit),
        .rd_i           (dec.rd),
        .rob_full_i     (rob_full_i),
        .rob_free_tag_i (rob_free_tag_i),
        .alu_rs_full_i  (alu_rs_full_i),
        .cmp_rs_full_i  (cmp_rs_full_i),
        .iq_read_o      (iq_read_o),
        .issue_alu_o    (issue_alu),
        .issue_cmp_o    (issue_cmp)
    );

    dispatch_regs u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .issue_alu_i (issue_alu),
        .issue_cmp_i (issue_cmp),
        .pc_i        (iq_entry_i.pc),
        .dec_i       (dec),
        .opcode_i    (iq_entry_i.instr[6:0]),
        .rs1_i       (opnd_j),
        .rs2_i       (opnd_k),
        .free_tag_i  (rob_free_tag_i),
        .alu_o       (alu_o),
        .cmp_o       (cmp_o),
        .rob_write_o (rob_write_o),
        .rob_entry_o (rob_entry_o),
        .tag_write_o (tag_write_o),
        .tag_rd_o    (tag_rd_o),
        .tag_o       (tag_o)
    );

endmodule

`default_nettype wire

// File: verilog/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass (
    input  issue_pkg::word_t     value_i,
    input  issue_pkg::rob_tag_t  tag_i,
    input  issue_pkg::rob_view_t rob_i,
    output issue_pkg::operand_t  opnd_o
);
    import issue_pkg::*;

    rob_slot_t slot;
    logic      hit;

    // producer slot named by the register file tag
    assign slot = rob_i[tag_i];
    assign hit  = (tag_i != '0) && slot.ready;

    always_comb begin
        if (hit) begin
            // result already in the ROB
            opnd_o.value = slot.value;
            opnd_o.tag   = '0;
        end else begin
            opnd_o.value = value_i;
            opnd_o.tag   = tag_i;
        end
        opnd_o.valid = (opnd_o.tag == '0);
    end

endmodule

`default_nettype wire
